// ==== csr_data.f ====
hw/csr_pkg.sv
hw/csr_counters.sv
hw/fcsr_file.sv
hw/machine_csr_regs.sv
hw/csr_read_mux.sv
hw/csr_data.sv
tb/tb_csr_data.sv

// ==== Bender.yml ====
package:
  name: csr_data

sources:
  - files:
      - hw/csr_pkg.sv
      - hw/csr_counters.sv
      - hw/fcsr_file.sv
      - hw/machine_csr_regs.sv
      - hw/csr_read_mux.sv
      - hw/csr_data.sv
  - target: test
    files:
      - tb/tb_csr_data.sv

// ==== tb/tb_csr_data.sv ====
// Testbench for the GPU core CSR block with a reference model of its state
`default_nettype none

module tb_csr_data;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_WARPS      = 4;
    localparam int NUM_THREADS    = 8;
    localparam int NUM_FPU_BLOCKS = 2;
    localparam int CORE_ID        = 3;
    localparam int WID_BITS       = $clog2(NUM_WARPS);
    // About twice the length of all tests together
    localparam int CYCLE_LIMIT    = 400;

    logic                                    clk;
    logic                                    reset;
    csr_pkg::xlen_t                          startup_arg;
    csr_pkg::csr_write_t                     csr_write;
    logic [WID_BITS-1:0]                     write_wid;
    logic                                    read_enable;
    csr_pkg::csr_addr_t                      read_addr;
    logic [WID_BITS-1:0]                     read_wid;
    csr_pkg::commit_count_t                  commit_count;
    logic [NUM_WARPS-1:0]                    active_warps;
    logic [NUM_WARPS-1:0][NUM_THREADS-1:0]   thread_masks;
    logic [NUM_FPU_BLOCKS-1:0]               fpu_flag_valid;
    logic [NUM_FPU_BLOCKS-1:0][WID_BITS-1:0] fpu_flag_wid;
    csr_pkg::fflags_t [NUM_FPU_BLOCKS-1:0]   fpu_flags;
    logic [NUM_FPU_BLOCKS-1:0][WID_BITS-1:0] fpu_read_wid;
    csr_pkg::xlen_t                          read_data_ro;
    csr_pkg::xlen_t                          read_data_rw;
    csr_pkg::frm_t [NUM_FPU_BLOCKS-1:0]      fpu_frm;

    // Reference model of the architectural state
    csr_pkg::xlen_t                 model_mscratch;
    logic [4:0]                     model_fflags [NUM_WARPS];
    logic [2:0]                     model_frm [NUM_WARPS];
    logic [63:0]                    model_cycles;
    logic [63:0]                    model_retired;
    csr_pkg::xlen_t                 exp_ro;
    csr_pkg::xlen_t                 exp_rw;
    logic [NUM_FPU_BLOCKS-1:0][2:0] exp_frm;

    logic [31:0] lfsr_state;
    int          error_count = 0;
    int          errors_at_start = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          cycle_count = 0;

    csr_pkg::csr_addr_t fp_addrs [3] = '{csr_pkg::CSR_FFLAGS, csr_pkg::CSR_FRM,
        csr_pkg::CSR_FCSR};
    csr_pkg::csr_addr_t noop_addrs [10] = '{csr_pkg::CSR_SATP, csr_pkg::CSR_MSTATUS,
        csr_pkg::CSR_MNSTATUS, csr_pkg::CSR_MEDELEG, csr_pkg::CSR_MIDELEG, csr_pkg::CSR_MIE,
        csr_pkg::CSR_MTVEC, csr_pkg::CSR_MEPC, csr_pkg::CSR_PMPCFG0, csr_pkg::CSR_PMPADDR0};
    csr_pkg::csr_addr_t ident_addrs [16] = '{csr_pkg::CSR_WARP_ID, csr_pkg::CSR_CORE_ID,
        csr_pkg::CSR_ACTIVE_THREADS, csr_pkg::CSR_ACTIVE_WARPS, csr_pkg::CSR_NUM_THREADS,
        csr_pkg::CSR_NUM_WARPS, csr_pkg::CSR_NUM_CORES, csr_pkg::CSR_LOCAL_MEM_BASE,
        csr_pkg::CSR_MISA, csr_pkg::CSR_MVENDORID, csr_pkg::CSR_MARCHID, csr_pkg::CSR_MIMPID,
        csr_pkg::CSR_MINSTRET, csr_pkg::CSR_MINSTRET_H, csr_pkg::CSR_MCYCLE,
        csr_pkg::CSR_MCYCLE_H};

    csr_data #(
        .NUM_WARPS      (NUM_WARPS),
        .NUM_THREADS    (NUM_THREADS),
        .NUM_FPU_BLOCKS (NUM_FPU_BLOCKS),
        .CORE_ID        (CORE_ID)
    ) csr_data_i (
        .clk            (clk),
        .reset          (reset),
        .startup_arg    (startup_arg),
        .csr_write      (csr_write),
        .write_wid      (write_wid),
        .read_enable    (read_enable),
        .read_addr      (read_addr),
        .read_wid       (read_wid),
        .commit_count   (commit_count),
        .active_warps   (active_warps),
        .thread_masks   (thread_masks),
        .fpu_flag_valid (fpu_flag_valid),
        .fpu_flag_wid   (fpu_flag_wid),
        .fpu_flags      (fpu_flags),
        .fpu_read_wid   (fpu_read_wid),
        .read_data_ro   (read_data_ro),
        .read_data_rw   (read_data_rw),
        .fpu_frm        (fpu_frm)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAIL");
            $finish;
        end
    end

    always @(posedge clk) begin : model_update
        logic [4:0] flags_n [NUM_WARPS];
        logic [2:0] frm_n [NUM_WARPS];
        if (reset) begin
            for (int w = 0; w < NUM_WARPS; w++) begin
                model_fflags[w] <= '0;
                model_frm[w]    <= '0;
            end
            model_mscratch <= startup_arg;
            model_cycles   <= '0;
            model_retired  <= '0;
        end else begin
            flags_n = model_fflags;
            frm_n   = model_frm;
            for (int b = 0; b < NUM_FPU_BLOCKS; b++) begin
                if (fpu_flag_valid[b]) begin
                    flags_n[fpu_flag_wid[b]] |= fpu_flags[b];
                end
            end
            // Software writes come after the FPU flags
            if (csr_write.enable) begin
                case (csr_write.addr)
                    csr_pkg::CSR_FFLAGS:   flags_n[write_wid] = csr_write.data[4:0];
                    csr_pkg::CSR_FRM:      frm_n[write_wid] = csr_write.data[2:0];
                    csr_pkg::CSR_FCSR: begin
                        frm_n[write_wid]   = csr_write.data[7:5];
                        flags_n[write_wid] = csr_write.data[4:0];
                    end
                    csr_pkg::CSR_MSCRATCH: model_mscratch <= csr_write.data;
                    default: ;
                endcase
            end
            model_fflags  <= flags_n;
            model_frm     <= frm_n;
            model_cycles  <= model_cycles + 64'd1;
            model_retired <= model_retired + 64'(commit_count);
        end
    end

    always_comb begin
        exp_ro = '0;
        exp_rw = '0;
        case (read_addr)
            csr_pkg::CSR_FFLAGS:         exp_rw = 32'(model_fflags[read_wid]);
            csr_pkg::CSR_FRM:            exp_rw = 32'(model_frm[read_wid]);
            csr_pkg::CSR_FCSR:           exp_rw = {24'b0, model_frm[read_wid], model_fflags[read_wid]};
            csr_pkg::CSR_MSCRATCH:       exp_rw = model_mscratch;
            csr_pkg::CSR_MCYCLE:         exp_ro = model_cycles[31:0];
            csr_pkg::CSR_MCYCLE_H:       exp_ro = model_cycles[63:32];
            csr_pkg::CSR_MINSTRET:       exp_ro = model_retired[31:0];
            csr_pkg::CSR_MINSTRET_H:     exp_ro = model_retired[63:32];
            csr_pkg::CSR_WARP_ID:        exp_ro = 32'(read_wid);
            csr_pkg::CSR_CORE_ID:        exp_ro = CORE_ID;
            csr_pkg::CSR_ACTIVE_THREADS: exp_ro = 32'(thread_masks[read_wid]);
            csr_pkg::CSR_ACTIVE_WARPS:   exp_ro = 32'(active_warps);
            csr_pkg::CSR_NUM_THREADS:    exp_ro = NUM_THREADS;
            csr_pkg::CSR_NUM_WARPS:      exp_ro = NUM_WARPS;
            csr_pkg::CSR_NUM_CORES:      exp_ro = csr_pkg::NUM_CORES_TOTAL;
            csr_pkg::CSR_LOCAL_MEM_BASE: exp_ro = csr_pkg::LMEM_BASE_ADDR;
            csr_pkg::CSR_MISA:           exp_ro = csr_pkg::MISA_VALUE;
            csr_pkg::CSR_MVENDORID:      exp_ro = csr_pkg::VENDOR_ID;
            csr_pkg::CSR_MARCHID:        exp_ro = csr_pkg::ARCHITECTURE_ID;
            csr_pkg::CSR_MIMPID:         exp_ro = csr_pkg::IMPLEMENTATION_ID;
            // No-op CSRs stay zero on both ports
            default: ;
        endcase
        for (int b = 0; b < NUM_FPU_BLOCKS; b++) begin
            exp_frm[b] = model_frm[fpu_read_wid[b]];
        end
    end

    a_read_ro: assert property (@(posedge clk) disable iff (reset) read_data_ro == exp_ro)
        else begin
            error_count++;
            $display("FAIL %0t: read_data_ro 0x%0h expected 0x%0h for CSR 0x%0h", $time,
                $sampled(read_data_ro), $sampled(exp_ro), $sampled(read_addr));
        end

    a_read_rw: assert property (@(posedge clk) disable iff (reset) read_data_rw == exp_rw)
        else begin
            error_count++;
            $display("FAIL %0t: read_data_rw 0x%0h expected 0x%0h for CSR 0x%0h", $time,
                $sampled(read_data_rw), $sampled(exp_rw), $sampled(read_addr));
        end

    a_fpu_frm: assert property (@(posedge clk) disable iff (reset) fpu_frm == exp_frm)
        else begin
            error_count++;
            $display("FAIL %0t: fpu_frm 0x%0h expected 0x%0h", $time,
                $sampled(fpu_frm), $sampled(exp_frm));
        end

    function automatic logic [31:0] galois_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = galois_step(lfsr_state);
        end
        return value;
    endfunction

    task automatic step();
        @(posedge clk);
        #2;
        commit_count     = csr_pkg::commit_count_t'(take_bits(3));
        csr_write.enable = 1'b0;
        fpu_flag_valid   = '0;
    endtask

    task automatic write_csr(input csr_pkg::csr_addr_t addr, input logic [WID_BITS-1:0] wid,
                             input csr_pkg::xlen_t data);
        csr_write.enable = 1'b1;
        csr_write.addr   = addr;
        csr_write.data   = data;
        write_wid        = wid;
    endtask

    task automatic read_csr(input csr_pkg::csr_addr_t addr, input logic [WID_BITS-1:0] wid);
        read_addr = addr;
        read_wid  = wid;
        step();
    endtask

    task automatic end_test(input string name);
        if (error_count == errors_at_start) begin
            tests_passed++;
            $display("%0t: %s passed", $time, name);
        end else begin
            tests_failed++;
            $display("%0t: %s failed with %0d errors", $time, name,
                error_count - errors_at_start);
        end
        errors_at_start = error_count;
    endtask

    initial begin
        logic [WID_BITS-1:0] wid;
        lfsr_state     = 32'd91439;
        reset          = 1'b1;
        startup_arg    = take_bits(32);
        csr_write      = '0;
        write_wid      = '0;
        read_enable    = 1'b0;
        read_addr      = csr_pkg::CSR_MSCRATCH;
        read_wid       = '0;
        commit_count   = '0;
        active_warps   = NUM_WARPS'(take_bits(NUM_WARPS));
        thread_masks   = take_bits(NUM_WARPS * NUM_THREADS);
        fpu_flag_valid = '0;
        fpu_flag_wid   = '0;
        fpu_flags      = '0;
        fpu_read_wid   = '0;
        step();
        step();
        reset       = 1'b0;
        read_enable = 1'b1;

        read_csr(csr_pkg::CSR_MSCRATCH, 0);
        for (int w = 0; w < NUM_WARPS; w++) begin
            for (int a = 0; a < 3; a++) begin
                read_csr(fp_addrs[a], WID_BITS'(w));
            end
        end
        read_csr(csr_pkg::CSR_MCYCLE, 0);
        foreach (noop_addrs[n]) begin
            write_csr(noop_addrs[n], WID_BITS'(take_bits(2)), take_bits(32));
            read_csr(noop_addrs[n], 0);
            // Read again once the write has passed an edge
            read_csr(noop_addrs[n], 0);
        end
        read_csr(csr_pkg::CSR_MSCRATCH, 0);
        end_test("after_reset");

        repeat (16) begin
            write_csr(csr_pkg::CSR_MSCRATCH, 0, take_bits(32));
            read_csr(csr_pkg::CSR_MSCRATCH, WID_BITS'(take_bits(2)));
        end
        read_csr(csr_pkg::CSR_MSCRATCH, 0);
        end_test("mscratch");

        repeat (32) begin
            write_csr(fp_addrs[take_bits(2) % 3], WID_BITS'(take_bits(2)), take_bits(32));
            fpu_read_wid = (NUM_FPU_BLOCKS * WID_BITS)'(take_bits(NUM_FPU_BLOCKS * WID_BITS));
            read_csr(fp_addrs[take_bits(2) % 3], WID_BITS'(take_bits(2)));
        end
        for (int w = 0; w < NUM_WARPS; w++) begin
            read_csr(csr_pkg::CSR_FCSR, WID_BITS'(w));
        end
        end_test("fp_csr");

        for (int i = 0; i < 24; i++) begin
            fpu_flag_valid = NUM_FPU_BLOCKS'(take_bits(NUM_FPU_BLOCKS));
            fpu_flag_wid   = (NUM_FPU_BLOCKS * WID_BITS)'(take_bits(NUM_FPU_BLOCKS * WID_BITS));
            fpu_flags      = (NUM_FPU_BLOCKS * 5)'(take_bits(NUM_FPU_BLOCKS * 5));
            fpu_read_wid   = (NUM_FPU_BLOCKS * WID_BITS)'(take_bits(NUM_FPU_BLOCKS * WID_BITS));
            if (i % 4 == 3) begin
                // Software write races block 0 on the same warp
                wid               = fpu_flag_wid[0];
                fpu_flag_valid[0] = 1'b1;
                write_csr(csr_pkg::CSR_FFLAGS, wid, take_bits(32));
                read_csr(csr_pkg::CSR_FFLAGS, WID_BITS'(take_bits(2)));
                read_csr(csr_pkg::CSR_FFLAGS, wid);
            end else begin
                read_csr(csr_pkg::CSR_FFLAGS, WID_BITS'(take_bits(2)));
            end
        end
        for (int w = 0; w < NUM_WARPS; w++) begin
            read_csr(csr_pkg::CSR_FCSR, WID_BITS'(w));
        end
        end_test("fpu_flags");

        repeat (2) begin
            active_warps = NUM_WARPS'(take_bits(NUM_WARPS));
            thread_masks = take_bits(NUM_WARPS * NUM_THREADS);
            foreach (ident_addrs[a]) begin
                read_csr(ident_addrs[a], WID_BITS'(take_bits(2)));
            end
        end
        end_test("identity");

        $display("Tests passed %0d, tests failed %0d, check errors %0d",
            tests_passed, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/csr_data.sv ====
// CSR block of one GPU core, joining register, counter and read-decode blocks
`default_nettype none

module csr_data #(
    parameter int NUM_WARPS      = 4,
    parameter int NUM_THREADS    = 4,
    parameter int NUM_FPU_BLOCKS = 2,
    parameter int CORE_ID        = 0,
    localparam int WID_BITS      = $clog2(NUM_WARPS)
) (
    input  wire                                        clk,
    input  wire                                        reset,
    input  wire csr_pkg::xlen_t                        startup_arg,
    input  wire csr_pkg::csr_write_t                   csr_write,
    input  wire [WID_BITS-1:0]                         write_wid,
    input  wire                                        read_enable,
    input  wire csr_pkg::csr_addr_t                    read_addr,
    input  wire [WID_BITS-1:0]                         read_wid,
    input  wire csr_pkg::commit_count_t                commit_count,
    input  wire [NUM_WARPS-1:0]                        active_warps,
    input  wire [NUM_WARPS-1:0][NUM_THREADS-1:0]       thread_masks,
    input  wire [NUM_FPU_BLOCKS-1:0]                   fpu_flag_valid,
    input  wire [NUM_FPU_BLOCKS-1:0][WID_BITS-1:0]     fpu_flag_wid,
    input  wire csr_pkg::fflags_t [NUM_FPU_BLOCKS-1:0] fpu_flags,
    input  wire [NUM_FPU_BLOCKS-1:0][WID_BITS-1:0]     fpu_read_wid,
    output csr_pkg::xlen_t                             read_data_ro,
    output csr_pkg::xlen_t                             read_data_rw,
    output csr_pkg::frm_t [NUM_FPU_BLOCKS-1:0]         fpu_frm
);

    csr_pkg::fp_csr_write_t fp_write;
    csr_pkg::xlen_t         mscratch;
    csr_pkg::fcsr_t         read_fcsr;
    csr_pkg::counter_t      mcycle;
    csr_pkg::counter_t      minstret;

    machine_csr_regs regs_i (
        .clk         (clk),
        .reset       (reset),
        .startup_arg (startup_arg),
        .csr_write   (csr_write),
        .fp_write    (fp_write),
        .mscratch    (mscratch)
    );

    fcsr_file #(
        .NUM_WARPS      (NUM_WARPS),
        .NUM_FPU_BLOCKS (NUM_FPU_BLOCKS)
    ) fcsr_i (
        .clk            (clk),
        .reset          (reset),
        .write_wid      (write_wid),
        .fp_write       (fp_write),
        .fpu_flag_valid (fpu_flag_valid),
        .fpu_flag_wid   (fpu_flag_wid),
        .fpu_flags      (fpu_flags),
        .fpu_read_wid   (fpu_read_wid),
        .read_wid       (read_wid),
        .fpu_frm        (fpu_frm),
        .read_fcsr      (read_fcsr)
    );

    csr_counters counters_i (
        .clk          (clk),
        .reset        (reset),
        .commit_count (commit_count),
        .mcycle       (mcycle),
        .minstret     (minstret)
    );

    csr_read_mux #(
        .NUM_WARPS   (NUM_WARPS),
        .NUM_THREADS (NUM_THREADS),
        .CORE_ID     (CORE_ID)
    ) read_mux_i (
        .clk          (clk),
        .reset        (reset),
        .read_enable  (read_enable),
        .read_addr    (read_addr),
        .read_wid     (read_wid),
        .mscratch     (mscratch),
        .read_fcsr    (read_fcsr),
        .mcycle       (mcycle),
        .minstret     (minstret),
        .active_warps (active_warps),
        .thread_masks (thread_masks),
        .read_data_ro (read_data_ro),
        .read_data_rw (read_data_rw)
    );

endmodule

`default_nettype wire

// ==== hw/csr_read_mux.sv ====
// CSR read decoder splitting read-only and read-write data
`default_nettype none

module csr_read_mux #(
    parameter int NUM_WARPS   = 4,
    parameter int NUM_THREADS = 4,
    parameter int CORE_ID     = 0,
    localparam int WID_BITS   = $clog2(NUM_WARPS)
) (
    input  wire                                  clk,
    input  wire                                  reset,
    input  wire                                  read_enable,
    input  wire csr_pkg::csr_addr_t              read_addr,
    input  wire [WID_BITS-1:0]                   read_wid,
    input  wire csr_pkg::xlen_t                  mscratch,
    input  wire csr_pkg::fcsr_t                  read_fcsr,
    input  wire csr_pkg::counter_t               mcycle,
    input  wire csr_pkg::counter_t               minstret,
    input  wire [NUM_WARPS-1:0]                  active_warps,
    input  wire [NUM_WARPS-1:0][NUM_THREADS-1:0] thread_masks,
    output csr_pkg::xlen_t                       read_data_ro,
    output csr_pkg::xlen_t                       read_data_rw
);

    logic read_addr_valid;

    always_comb begin
        read_data_ro    = '0;
        read_data_rw    = '0;
        read_addr_valid = 1'b1;
        case (read_addr)
            csr_pkg::CSR_MVENDORID: read_data_ro = csr_pkg::VENDOR_ID;
            csr_pkg::CSR_MARCHID:   read_data_ro = csr_pkg::ARCHITECTURE_ID;
            csr_pkg::CSR_MIMPID:    read_data_ro = csr_pkg::IMPLEMENTATION_ID;
            csr_pkg::CSR_MISA:      read_data_ro = csr_pkg::MISA_VALUE;

            csr_pkg::CSR_FFLAGS:   read_data_rw = csr_pkg::xlen_t'(read_fcsr.fflags);
            csr_pkg::CSR_FRM:      read_data_rw = csr_pkg::xlen_t'(read_fcsr.frm);
            csr_pkg::CSR_FCSR:     read_data_rw = csr_pkg::xlen_t'(read_fcsr);
            csr_pkg::CSR_MSCRATCH: read_data_rw = mscratch;

            csr_pkg::CSR_WARP_ID:  read_data_ro = csr_pkg::xlen_t'(read_wid);
            csr_pkg::CSR_CORE_ID:  read_data_ro = csr_pkg::xlen_t'(CORE_ID);
            csr_pkg::CSR_ACTIVE_THREADS: begin
                read_data_ro = csr_pkg::xlen_t'(thread_masks[read_wid]);
            end
            csr_pkg::CSR_ACTIVE_WARPS:   read_data_ro = csr_pkg::xlen_t'(active_warps);
            csr_pkg::CSR_NUM_THREADS:    read_data_ro = csr_pkg::xlen_t'(NUM_THREADS);
            csr_pkg::CSR_NUM_WARPS:      read_data_ro = csr_pkg::xlen_t'(NUM_WARPS);
            csr_pkg::CSR_NUM_CORES:      read_data_ro = csr_pkg::NUM_CORES_TOTAL;
            csr_pkg::CSR_LOCAL_MEM_BASE: read_data_ro = csr_pkg::LMEM_BASE_ADDR;

            // 64-bit counters, high half sits one offset above the low half
            csr_pkg::CSR_MCYCLE:     read_data_ro = mcycle[31:0];
            csr_pkg::CSR_MCYCLE_H:   read_data_ro = mcycle[63:32];
            csr_pkg::CSR_MINSTRET:   read_data_ro = minstret[31:0];
            csr_pkg::CSR_MINSTRET_H: read_data_ro = minstret[63:32];

            // Implemented as no-ops, always zero
            csr_pkg::CSR_SATP,
            csr_pkg::CSR_MSTATUS,
            csr_pkg::CSR_MNSTATUS,
            csr_pkg::CSR_MEDELEG,
            csr_pkg::CSR_MIDELEG,
            csr_pkg::CSR_MIE,
            csr_pkg::CSR_MTVEC,
            csr_pkg::CSR_MEPC,
            csr_pkg::CSR_PMPCFG0,
            csr_pkg::CSR_PMPADDR0: read_data_ro = '0;

            default: read_addr_valid = 1'b0;
        endcase
    end

    a_read_addr: assert property (@(posedge clk) disable iff (reset)
        read_enable |-> read_addr_valid)
        else $error("%t: invalid CSR read address 0x%0h", $time, read_addr);

endmodule

`default_nettype wire

// ==== hw/machine_csr_regs.sv ====
// Machine CSR write decoder, holds mscratch and forwards FP CSR writes
`default_nettype none

module machine_csr_regs (
    input  wire                      clk,
    input  wire                      reset,
    input  wire csr_pkg::xlen_t      startup_arg,
    input  wire csr_pkg::csr_write_t csr_write,
    output csr_pkg::fp_csr_write_t   fp_write,
    output csr_pkg::xlen_t           mscratch
);

    logic write_addr_valid;
    logic mscratch_en;

    always_comb begin
        fp_write         = '0;
        fp_write.data    = csr_write.data[7:0];
        mscratch_en      = 1'b0;
        write_addr_valid = 1'b1;
        case (csr_write.addr)
            csr_pkg::CSR_FFLAGS: fp_write.fflags_en = csr_write.enable;
            csr_pkg::CSR_FRM: begin
                // frm payload comes from the low bits of the word
                fp_write.frm_en   = csr_write.enable;
                fp_write.data.frm = csr_write.data[2:0];
            end
            csr_pkg::CSR_FCSR:     fp_write.fcsr_en = csr_write.enable;
            csr_pkg::CSR_MSCRATCH: mscratch_en = csr_write.enable;
            csr_pkg::CSR_SATP,
            csr_pkg::CSR_MSTATUS,
            csr_pkg::CSR_MNSTATUS,
            csr_pkg::CSR_MEDELEG,
            csr_pkg::CSR_MIDELEG,
            csr_pkg::CSR_MIE,
            csr_pkg::CSR_MTVEC,
            csr_pkg::CSR_MEPC,
            csr_pkg::CSR_PMPCFG0,
            csr_pkg::CSR_PMPADDR0: ;
            default: write_addr_valid = 1'b0;
        endcase
    end

    // Startup argument lands here at reset
    always_ff @(posedge clk) begin
        if (reset) begin
            mscratch <= startup_arg;
        end else if (mscratch_en) begin
            mscratch <= csr_write.data;
        end
    end

    a_write_addr: assert property (@(posedge clk) disable iff (reset)
        csr_write.enable |-> write_addr_valid)
        else $error("%t: invalid CSR write address 0x%0h", $time, csr_write.addr);

endmodule

`default_nettype wire

// ==== hw/fcsr_file.sv ====
// Per-warp floating-point CSR storage with FPU flag accumulation
`default_nettype none

module fcsr_file #(
    parameter int NUM_WARPS      = 4,
    parameter int NUM_FPU_BLOCKS = 2,
    localparam int WID_BITS      = $clog2(NUM_WARPS)
) (
    input  wire                                        clk,
    input  wire                                        reset,
    input  wire [WID_BITS-1:0]                         write_wid,
    input  wire csr_pkg::fp_csr_write_t                fp_write,
    input  wire [NUM_FPU_BLOCKS-1:0]                   fpu_flag_valid,
    input  wire [NUM_FPU_BLOCKS-1:0][WID_BITS-1:0]     fpu_flag_wid,
    input  wire csr_pkg::fflags_t [NUM_FPU_BLOCKS-1:0] fpu_flags,
    input  wire [NUM_FPU_BLOCKS-1:0][WID_BITS-1:0]     fpu_read_wid,
    input  wire [WID_BITS-1:0]                         read_wid,
    output csr_pkg::frm_t [NUM_FPU_BLOCKS-1:0]         fpu_frm,
    output csr_pkg::fcsr_t                             read_fcsr
);

    csr_pkg::fcsr_t [NUM_WARPS-1:0] fcsr_q;
    csr_pkg::fcsr_t [NUM_WARPS-1:0] fcsr_n;
    logic                           sw_write;

    assign sw_write = fp_write.fflags_en | fp_write.frm_en | fp_write.fcsr_en;

    always_comb begin
        fcsr_n = fcsr_q;
        // Two blocks may hit the same warp, so accumulate into fcsr_n
        for (int i = 0; i < NUM_FPU_BLOCKS; i++) begin
            if (fpu_flag_valid[i]) begin
                fcsr_n[fpu_flag_wid[i]].fflags = fcsr_n[fpu_flag_wid[i]].fflags | fpu_flags[i];
            end
        end
        // Software write applied last so it wins over FPU flags
        if (fp_write.fcsr_en) begin
            fcsr_n[write_wid] = fp_write.data;
        end
        if (fp_write.fflags_en) begin
            fcsr_n[write_wid].fflags = fp_write.data.fflags;
        end
        if (fp_write.frm_en) begin
            fcsr_n[write_wid].frm = fp_write.data.frm;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fcsr_q <= '0;
        end else begin
            fcsr_q <= fcsr_n;
        end
    end

    assign read_fcsr = fcsr_q[read_wid];

    for (genvar i = 0; i < NUM_FPU_BLOCKS; i++) begin : g_fpu_port
        assign fpu_frm[i] = fcsr_q[fpu_read_wid[i]].frm;

        a_fpu_wid: assert property (@(posedge clk) disable iff (reset)
            (!fpu_flag_valid[i] || fpu_flag_wid[i] < NUM_WARPS) && fpu_read_wid[i] < NUM_WARPS)
            else $error("%t: FPU block %0d warp id out of range", $time, i);
    end

    a_sw_wid: assert property (@(posedge clk) disable iff (reset)
        (!sw_write || write_wid < NUM_WARPS) && read_wid < NUM_WARPS)
        else $error("%t: CSR warp id out of range", $time);

endmodule

`default_nettype wire

// ==== hw/csr_counters.sv ====
// 64-bit cycle and retired-instruction counters
`default_nettype none

module csr_counters (
    input  wire                         clk,
    input  wire                         reset,
    input  wire csr_pkg::commit_count_t commit_count,
    output csr_pkg::counter_t           mcycle,
    output csr_pkg::counter_t           minstret
);

    always_ff @(posedge clk) begin
        if (reset) begin
            mcycle   <= '0;
            minstret <= '0;
        end else begin
            mcycle   <= mcycle + 64'd1;
            // Several instructions may retire in one cycle
            minstret <= minstret + csr_pkg::counter_t'(commit_count);
        end
    end

endmodule

`default_nettype wire

// ==== hw/csr_pkg.sv ====
// CSR package with shared widths, CSR addresses, identity words and request structs
`default_nettype none

package csr_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [11:0]     csr_addr_t;
    typedef logic [4:0]      fflags_t;
    typedef logic [2:0]      frm_t;
    typedef logic [63:0]     counter_t;

    // Instructions retired in one cycle
    typedef logic [3:0]      commit_count_t;

    typedef struct packed {
        frm_t    frm;
        fflags_t fflags;
    } fcsr_t;

    localparam csr_addr_t CSR_HIGH_OFFSET = 12'h080;

    localparam csr_addr_t CSR_FFLAGS         = 12'h001;
    localparam csr_addr_t CSR_FRM            = 12'h002;
    localparam csr_addr_t CSR_FCSR           = 12'h003;
    localparam csr_addr_t CSR_SATP           = 12'h180;
    localparam csr_addr_t CSR_MSTATUS        = 12'h300;
    localparam csr_addr_t CSR_MISA           = 12'h301;
    localparam csr_addr_t CSR_MEDELEG        = 12'h302;
    localparam csr_addr_t CSR_MIDELEG        = 12'h303;
    localparam csr_addr_t CSR_MIE            = 12'h304;
    localparam csr_addr_t CSR_MTVEC          = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH       = 12'h340;
    localparam csr_addr_t CSR_MEPC           = 12'h341;
    localparam csr_addr_t CSR_PMPCFG0        = 12'h3A0;
    localparam csr_addr_t CSR_PMPADDR0       = 12'h3B0;
    localparam csr_addr_t CSR_MNSTATUS       = 12'h744;
    localparam csr_addr_t CSR_MCYCLE         = 12'hB00;
    localparam csr_addr_t CSR_MCYCLE_H       = CSR_MCYCLE + CSR_HIGH_OFFSET;
    localparam csr_addr_t CSR_MINSTRET       = 12'hB02;
    localparam csr_addr_t CSR_MINSTRET_H     = CSR_MINSTRET + CSR_HIGH_OFFSET;
    localparam csr_addr_t CSR_WARP_ID        = 12'hCC2;
    localparam csr_addr_t CSR_CORE_ID        = 12'hCC4;
    localparam csr_addr_t CSR_ACTIVE_WARPS   = 12'hCC5;
    localparam csr_addr_t CSR_ACTIVE_THREADS = 12'hCC6;
    localparam csr_addr_t CSR_MVENDORID      = 12'hF11;
    localparam csr_addr_t CSR_MARCHID        = 12'hF12;
    localparam csr_addr_t CSR_MIMPID         = 12'hF13;
    localparam csr_addr_t CSR_NUM_THREADS    = 12'hFC0;
    localparam csr_addr_t CSR_NUM_WARPS      = 12'hFC1;
    localparam csr_addr_t CSR_NUM_CORES      = 12'hFC2;
    localparam csr_addr_t CSR_LOCAL_MEM_BASE = 12'hFC3;

    localparam xlen_t VENDOR_ID         = 32'h0000_0000;
    localparam xlen_t ARCHITECTURE_ID   = 32'h0000_0001;
    localparam xlen_t IMPLEMENTATION_ID = 32'h0000_0001;
    // MXL=1 (RV32), extensions I, M and F
    localparam xlen_t MISA_VALUE        = {2'b01, 30'h0000_1120};
    localparam xlen_t NUM_CORES_TOTAL   = 32'd1;
    localparam xlen_t LMEM_BASE_ADDR    = 32'hFFFF_0000;

    typedef struct packed {
        logic      enable;
        csr_addr_t addr;
        xlen_t     data;
    } csr_write_t;

    typedef struct packed {
        logic  fflags_en;
        logic  frm_en;
        logic  fcsr_en;
        fcsr_t data;
    } fp_csr_write_t;

endpackage

`default_nettype wire
